// File: design/cpu_types_pkg.sv
/*
  cpu types package
  opcode, funct and alu op codes, mux select codes,
  the instruction word views and the reset pc
*/
package cpu_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regbits_t;

  // primary opcodes, standard mips values
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    JAL   = 6'h03,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    SLTI  = 6'h0a,
    ANDI  = 6'h0c,
    ORI   = 6'h0d,
    XORI  = 6'h0e,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcode_t;

  // r-type function field
  typedef enum logic [5:0] {
    JR   = 6'h08,
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    XOR  = 6'h26,
    NOR  = 6'h27,
    SLT  = 6'h2a,
    SLTU = 6'h2b
  } funct_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU
  } aluop_t;

  // three views of the same fetched word
  typedef struct packed {
    opcode_t  opcode;
    regbits_t rs;
    regbits_t rt;
    regbits_t rd;
    logic [4:0] shamt;
    funct_t   funct;
  } r_t;

  typedef struct packed {
    opcode_t  opcode;
    regbits_t rs;
    regbits_t rt;
    logic [15:0] imm16;
  } i_t;

  typedef struct packed {
    opcode_t opcode;
    logic [25:0] addr26;
  } j_t;

  typedef union packed {
    r_t r;
    i_t i;
    j_t j;
  } instr_t;

  // datapath mux selects
  typedef enum logic {SEL_REG_DATA, SEL_IMM16} alusrc_t;
  typedef enum logic [1:0] {SEL_RD, SEL_RT, SEL_RA} regdst_t;
  typedef enum logic [1:0] {SEL_RESULT, SEL_NPC, SEL_DLOAD, SEL_LUI} memtoreg_t;
  typedef enum logic [1:0] {PC_NEXT, PC_BRANCH, PC_JUMP, PC_JR} pcsrc_t;

  localparam word_t PC_INIT = 32'h0000_0000;

endpackage

// File: design/alu.sv
/*
  alu
  eight combinational operations with zero and signed overflow flags
*/
`timescale 1ns/1ps

module alu (
  input  cpu_types_pkg::word_t  port_a,
  input  cpu_types_pkg::word_t  port_b,
  input  cpu_types_pkg::aluop_t alu_op,
  output cpu_types_pkg::word_t  result,
  output logic                  zero,
  output logic                  overflow
);

  always_comb begin
    result = '0;
    case (alu_op)
      cpu_types_pkg::ALU_ADD:  result = port_a + port_b;
      cpu_types_pkg::ALU_SUB:  result = port_a - port_b;
      cpu_types_pkg::ALU_AND:  result = port_a & port_b;
      cpu_types_pkg::ALU_OR:   result = port_a | port_b;
      cpu_types_pkg::ALU_XOR:  result = port_a ^ port_b;
      cpu_types_pkg::ALU_NOR:  result = ~(port_a | port_b);
      cpu_types_pkg::ALU_SLT:  result = {31'b0, $signed(port_a) < $signed(port_b)};
      cpu_types_pkg::ALU_SLTU: result = {31'b0, port_a < port_b};
      default:                 result = '0;
    endcase
  end

  // on subtract this is the branch equal flag
  assign zero = (result == '0);

  // signed overflow, flagged only, no trap
  always_comb begin
    overflow = 1'b0;
    if (alu_op == cpu_types_pkg::ALU_ADD)
      overflow = (port_a[31] == port_b[31]) && (result[31] != port_a[31]);
    else if (alu_op == cpu_types_pkg::ALU_SUB)
      overflow = (port_a[31] != port_b[31]) && (result[31] != port_a[31]);
  end

endmodule

// File: design/control_unit.sv
/*
  control unit
  decodes the fetched word into alu op, mux selects, register write,
  data requests, next pc choice and halt
*/
`timescale 1ns/1ps

module control_unit (
  input  cpu_types_pkg::instr_t    instr,
  input  logic                     equal,
  output cpu_types_pkg::aluop_t    alu_op,
  output cpu_types_pkg::alusrc_t   alu_src,
  output cpu_types_pkg::regdst_t   reg_dst,
  output cpu_types_pkg::memtoreg_t mem_to_reg,
  output cpu_types_pkg::pcsrc_t    pc_src,
  output logic                     ext_sign,
  output logic                     reg_wen,
  output logic                     d_ren,
  output logic                     d_wen,
  output logic                     halt_req
);

  always_comb begin
    // defaults give a no-op
    alu_op     = cpu_types_pkg::ALU_ADD;
    alu_src    = cpu_types_pkg::SEL_REG_DATA;
    reg_dst    = cpu_types_pkg::SEL_RT;
    mem_to_reg = cpu_types_pkg::SEL_RESULT;
    pc_src     = cpu_types_pkg::PC_NEXT;
    ext_sign   = 1'b0;
    reg_wen    = 1'b0;
    d_ren      = 1'b0;
    d_wen      = 1'b0;
    halt_req   = 1'b0;

    case (instr.r.opcode)
      cpu_types_pkg::RTYPE: begin
        reg_dst = cpu_types_pkg::SEL_RD;
        reg_wen = 1'b1;
        case (instr.r.funct)
          cpu_types_pkg::ADDU: alu_op = cpu_types_pkg::ALU_ADD;
          cpu_types_pkg::SUBU: alu_op = cpu_types_pkg::ALU_SUB;
          cpu_types_pkg::AND:  alu_op = cpu_types_pkg::ALU_AND;
          cpu_types_pkg::OR:   alu_op = cpu_types_pkg::ALU_OR;
          cpu_types_pkg::XOR:  alu_op = cpu_types_pkg::ALU_XOR;
          cpu_types_pkg::NOR:  alu_op = cpu_types_pkg::ALU_NOR;
          cpu_types_pkg::SLT:  alu_op = cpu_types_pkg::ALU_SLT;
          cpu_types_pkg::SLTU: alu_op = cpu_types_pkg::ALU_SLTU;
          cpu_types_pkg::JR: begin
            // target comes from rs, nothing written
            pc_src  = cpu_types_pkg::PC_JR;
            reg_wen = 1'b0;
          end
          default: reg_wen = 1'b0;
        endcase
      end
      // immediates, sign or zero extended
      cpu_types_pkg::ADDIU,
      cpu_types_pkg::SLTI,
      cpu_types_pkg::ANDI,
      cpu_types_pkg::ORI,
      cpu_types_pkg::XORI: begin
        alu_src  = cpu_types_pkg::SEL_IMM16;
        reg_wen  = 1'b1;
        ext_sign = (instr.i.opcode == cpu_types_pkg::ADDIU) ||
                   (instr.i.opcode == cpu_types_pkg::SLTI);
        if (instr.i.opcode == cpu_types_pkg::SLTI)
          alu_op = cpu_types_pkg::ALU_SLT;
        else if (instr.i.opcode == cpu_types_pkg::ANDI)
          alu_op = cpu_types_pkg::ALU_AND;
        else if (instr.i.opcode == cpu_types_pkg::ORI)
          alu_op = cpu_types_pkg::ALU_OR;
        else if (instr.i.opcode == cpu_types_pkg::XORI)
          alu_op = cpu_types_pkg::ALU_XOR;
      end
      cpu_types_pkg::LUI: begin
        mem_to_reg = cpu_types_pkg::SEL_LUI;
        reg_wen    = 1'b1;
      end
      // address is rs plus signed offset
      cpu_types_pkg::LW: begin
        alu_src    = cpu_types_pkg::SEL_IMM16;
        ext_sign   = 1'b1;
        mem_to_reg = cpu_types_pkg::SEL_DLOAD;
        reg_wen    = 1'b1;
        d_ren      = 1'b1;
      end
      cpu_types_pkg::SW: begin
        alu_src  = cpu_types_pkg::SEL_IMM16;
        ext_sign = 1'b1;
        d_wen    = 1'b1;
      end
      // equal comes from the alu subtract
      cpu_types_pkg::BEQ,
      cpu_types_pkg::BNE: begin
        alu_op   = cpu_types_pkg::ALU_SUB;
        ext_sign = 1'b1;
        if (equal == (instr.i.opcode == cpu_types_pkg::BEQ))
          pc_src = cpu_types_pkg::PC_BRANCH;
      end
      cpu_types_pkg::J: pc_src = cpu_types_pkg::PC_JUMP;
      cpu_types_pkg::JAL: begin
        pc_src     = cpu_types_pkg::PC_JUMP;
        reg_dst    = cpu_types_pkg::SEL_RA;
        mem_to_reg = cpu_types_pkg::SEL_NPC;
        reg_wen    = 1'b1;
      end
      cpu_types_pkg::HALT: halt_req = 1'b1;
      default: reg_wen = 1'b0;
    endcase
  end

endmodule

// File: design/register_file.sv
/*
  register file
  32 x 32 bits, two combinational reads, one write at the edge,
  register 0 reads as zero
*/
`timescale 1ns/1ps

module register_file (
  input  logic                    CLK,
  input  logic                    reset,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::word_t    wdat,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);

  cpu_types_pkg::word_t regs [32];

  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end else if (wen && (wsel != '0)) begin
      // writes to r0 dropped here
      regs[wsel] <= wdat;
    end
  end

  assign rdat1 = regs[rsel1];
  assign rdat2 = regs[rsel2];

  a_r0_reads_zero: assert property (@(posedge CLK) disable iff (reset)
    ((rsel1 == '0) -> (rdat1 == '0)) && ((rsel2 == '0) -> (rdat2 == '0)));

endmodule

// File: design/pc.sv
/*
  program counter
  advances on pc_en to pc+4, a branch target, a jump target
  or a register target
*/
`timescale 1ns/1ps

module pc (
  input  logic                  CLK,
  input  logic                  reset,
  input  logic                  pc_en,
  input  cpu_types_pkg::pcsrc_t pc_src,
  input  cpu_types_pkg::word_t  br_offset,
  input  cpu_types_pkg::word_t  jmp_addr,
  input  cpu_types_pkg::word_t  jr_addr,
  output cpu_types_pkg::word_t  imemaddr
);

  cpu_types_pkg::word_t pc_q;
  cpu_types_pkg::word_t npc;
  cpu_types_pkg::word_t pc_d;

  assign npc = pc_q + 32'd4;

  always_comb begin
    pc_d = npc;
    case (pc_src)
      cpu_types_pkg::PC_BRANCH: pc_d = npc + br_offset;
      // region bits from pc+4
      cpu_types_pkg::PC_JUMP:   pc_d = {npc[31:28], jmp_addr[27:0]};
      cpu_types_pkg::PC_JR:     pc_d = jr_addr;
      default:                  pc_d = npc;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset)
      pc_q <= cpu_types_pkg::PC_INIT;
    else if (pc_en)
      pc_q <= pc_d;
  end

  assign imemaddr = pc_q;

  // a jr through a bad register would break this
  a_pc_aligned: assert property (@(posedge CLK) disable iff (reset)
    imemaddr[1:0] == 2'b00);

endmodule

// File: design/request_unit.sv
/*
  request unit
  issues and holds data strobes until dhit, gates the pc advance,
  latches halt
*/
`timescale 1ns/1ps

module request_unit (
  input  logic CLK,
  input  logic reset,
  input  logic d_ren,
  input  logic d_wen,
  input  logic halt_req,
  input  logic ihit,
  input  logic dhit,
  output logic imemREN,
  output logic dmemREN,
  output logic dmemWEN,
  output logic pc_en,
  output logic halt
);

  logic ren_q;
  logic wen_q;
  logic done_q;
  logic halt_q;
  logic need;
  logic pending;
  logic first;

  assign need    = d_ren | d_wen;
  assign pending = ren_q | wen_q;

  // first cycle of a fresh data access
  // held off right after a completion, the fetch side may still show that word
  assign first = ihit & need & ~pending & ~done_q & ~halt_q;

  assign dmemREN = ren_q | (first & d_ren);
  assign dmemWEN = wen_q | (first & d_wen);

  // memory ops commit on dhit, everything else on ihit
  assign pc_en = ~halt_q & ~halt_req & ((ihit & ~need) | (dhit & pending));

  always_ff @(posedge CLK) begin
    if (reset) begin
      ren_q  <= 1'b0;
      wen_q  <= 1'b0;
      done_q <= 1'b0;
      halt_q <= 1'b0;
    end else begin
      // dhit wins over a new request
      ren_q  <= dhit ? 1'b0 : (ren_q | (first & d_ren));
      wen_q  <= dhit ? 1'b0 : (wen_q | (first & d_wen));
      done_q <= dhit & pending;
      halt_q <= halt_q | (ihit & halt_req);
    end
  end

  assign halt    = halt_q;
  assign imemREN = ~halt_q;

  a_one_strobe: assert property (@(posedge CLK) disable iff (reset)
    !(dmemREN && dmemWEN));

endmodule

// File: design/datapath.sv
/*
  datapath
  single-cycle mips core top, joins pc, control, register file,
  alu and request unit with the extender and glue muxes
*/
`timescale 1ns/1ps

module datapath (
  input  logic                 CLK,
  input  logic                 reset,
  input  logic                 ihit,
  input  cpu_types_pkg::word_t imemload,
  input  logic                 dhit,
  input  cpu_types_pkg::word_t dmemload,
  output logic                 imemREN,
  output cpu_types_pkg::word_t imemaddr,
  output logic                 dmemREN,
  output logic                 dmemWEN,
  output cpu_types_pkg::word_t dmemaddr,
  output cpu_types_pkg::word_t dmemstore,
  output logic                 halt
);

  cpu_types_pkg::instr_t    instr;
  cpu_types_pkg::aluop_t    alu_op;
  cpu_types_pkg::alusrc_t   alu_src;
  cpu_types_pkg::regdst_t   reg_dst;
  cpu_types_pkg::memtoreg_t mem_to_reg;
  cpu_types_pkg::pcsrc_t    pc_src;
  logic ext_sign, reg_wen, d_ren, d_wen, halt_req, pc_en, equal;
  cpu_types_pkg::word_t     rdat1, rdat2, imm_ext, port_b, result, wdat, npc;
  cpu_types_pkg::word_t     br_offset, jmp_addr;
  cpu_types_pkg::regbits_t  wsel;

  assign instr = imemload;
  assign npc   = imemaddr + 32'd4;

  control_unit i_control_unit (
    .instr, .equal, .alu_op, .alu_src, .reg_dst, .mem_to_reg, .pc_src,
    .ext_sign, .reg_wen, .d_ren, .d_wen, .halt_req
  );

  request_unit i_request_unit (
    .CLK, .reset, .d_ren, .d_wen, .halt_req, .ihit, .dhit,
    .imemREN, .dmemREN, .dmemWEN, .pc_en, .halt
  );

  // commit only when the pc moves
  register_file i_register_file (
    .CLK, .reset, .wen(reg_wen & pc_en), .wsel, .wdat,
    .rsel1(instr.r.rs), .rsel2(instr.r.rt), .rdat1, .rdat2
  );

  // overflow is not trapped
  alu i_alu (
    .port_a(rdat1), .port_b, .alu_op, .result, .zero(equal), .overflow()
  );

  pc i_pc (
    .CLK, .reset, .pc_en, .pc_src, .br_offset, .jmp_addr, .jr_addr(rdat1), .imemaddr
  );

  // zero or sign extend imm16
  assign imm_ext = ext_sign ? {{16{instr.i.imm16[15]}}, instr.i.imm16}
                            : {16'h0000, instr.i.imm16};

  // word offsets to byte offsets
  assign br_offset = {imm_ext[29:0], 2'b00};
  assign jmp_addr  = {4'b0000, instr.j.addr26, 2'b00};

  assign port_b = (alu_src == cpu_types_pkg::SEL_IMM16) ? imm_ext : rdat2;

  always_comb begin
    wsel = instr.r.rt;
    case (reg_dst)
      cpu_types_pkg::SEL_RD: wsel = instr.r.rd;
      // link register for jal
      cpu_types_pkg::SEL_RA: wsel = 5'd31;
      default:               wsel = instr.r.rt;
    endcase
  end

  always_comb begin
    wdat = result;
    case (mem_to_reg)
      cpu_types_pkg::SEL_NPC:   wdat = npc;
      cpu_types_pkg::SEL_DLOAD: wdat = dmemload;
      cpu_types_pkg::SEL_LUI:   wdat = {instr.i.imm16, 16'h0000};
      default:                  wdat = result;
    endcase
  end

  // data side, stable while the instruction waits
  assign dmemaddr  = result;
  assign dmemstore = rdat2;

endmodule

// File: tb/datapath_tb.sv
/*
  datapath testbench
  plays instruction and data memory for the single-cycle core,
  walks a program table and checks fetch addresses and data requests
*/
`timescale 1ns/1ps

module datapath_tb;

  // access kinds in the table
  localparam int NONE_ACC  = 0;
  localparam int READ_ACC  = 1;
  localparam int WRITE_ACC = 2;

  logic CLK = 1'b0;
  logic reset;
  logic ihit;
  logic dhit;
  cpu_types_pkg::word_t imemload;
  cpu_types_pkg::word_t dmemload;
  logic imemREN;
  logic dmemREN;
  logic dmemWEN;
  logic halt;
  cpu_types_pkg::word_t imemaddr;
  cpu_types_pkg::word_t dmemaddr;
  cpu_types_pkg::word_t dmemstore;

  // program table, one row per fetch
  logic [31:0] row_instr  [64];
  logic [31:0] row_pc     [64];
  int          row_kind   [64];
  logic [31:0] row_daddr  [64];
  logic [31:0] row_dstore [64];
  int          row_ref    [64];
  logic [31:0] draws      [64];
  logic [31:0] dmem       [64];
  int nrows = 0;
  int lw_a;
  int lw_b;
  int lw_c;
  int limit = 1000;
  int cycles = 0;
  integer seed;
  logic prev_mem = 1'b0;

  datapath i_datapath (
    .CLK, .reset, .ihit, .imemload, .dhit, .dmemload,
    .imemREN, .imemaddr, .dmemREN, .dmemWEN, .dmemaddr, .dmemstore, .halt
  );

  always #5 CLK = ~CLK;

  // run length guard
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("Timeout: the program did not finish within %0d cycles", limit);
      $display("Simulation failed");
      $fatal(1, "run stopped by cycle limit");
    end
  end

  task automatic compare_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "stopped on first mismatch");
    end
  endtask

  // mips encoders
  function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                        input logic [4:0] rd, input logic [5:0] funct);
    return {6'h00, rs, rt, rd, 5'd0, funct};
  endfunction

  function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                        input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [31:0] target);
    return {op, target[27:2]};
  endfunction

  task automatic add_mem(input logic [31:0] instr, input logic [31:0] pc, input int kind,
                         input logic [31:0] daddr, input logic [31:0] dstore,
                         input int ref_row);
    row_instr[nrows]  = instr;
    row_pc[nrows]     = pc;
    row_kind[nrows]   = kind;
    row_daddr[nrows]  = daddr;
    row_dstore[nrows] = dstore;
    row_ref[nrows]    = ref_row;
    nrows++;
  endtask

  task automatic add_op(input logic [31:0] instr, input logic [31:0] pc);
    add_mem(instr, pc, NONE_ACC, 32'h0, 32'h0, -1);
  endtask

  // expected values worked out by hand
  task automatic build_program();
    add_op(enc_i(6'h09, 0, 1, 16'h0010), 32'h00);   // addiu r1 = 0x10
    add_op(enc_i(6'h0d, 0, 2, 16'hf0f0), 32'h04);   // ori r2 = 0xf0f0
    add_op(enc_i(6'h0f, 0, 3, 16'h8000), 32'h08);   // lui r3 = 0x80000000
    add_op(enc_i(6'h09, 0, 4, 16'hfffd), 32'h0c);   // addiu r4 = -3
    add_op(enc_r(2, 1, 5, 6'h23), 32'h10);          // subu r5 = 0xf0e0
    add_op(enc_r(4, 1, 6, 6'h2a), 32'h14);          // slt r6 = 1, signed
    add_op(enc_r(1, 4, 7, 6'h2b), 32'h18);          // sltu r7 = 1, unsigned
    add_op(enc_r(6, 7, 8, 6'h21), 32'h1c);          // addu r8 = 2
    add_op(enc_r(8, 3, 8, 6'h25), 32'h20);          // or r8 = 0x80000002
    add_mem(enc_i(6'h2b, 1, 5, 16'h0000), 32'h24, WRITE_ACC, 32'h10, 32'h0000f0e0, -1);
    // negative offset
    add_mem(enc_i(6'h2b, 1, 8, 16'hfffc), 32'h28, WRITE_ACC, 32'h0c, 32'h80000002, -1);
    add_op(enc_r(2, 0, 9, 6'h27), 32'h2c);          // nor r9 = 0xffff0f0f
    add_op(enc_i(6'h0e, 9, 10, 16'h00ff), 32'h30);  // xori r10 = 0xffff0ff0
    add_op(enc_r(10, 2, 11, 6'h24), 32'h34);        // and r11 = 0xf0
    add_op(enc_i(6'h0c, 4, 12, 16'h00ff), 32'h38);  // andi r12 = 0xfd
    add_op(enc_r(11, 12, 13, 6'h26), 32'h3c);       // xor r13 = 0x0d
    add_op(enc_i(6'h0a, 4, 14, 16'hfffe), 32'h40);  // slti r14 = 1
    add_op(enc_r(13, 14, 13, 6'h21), 32'h44);       // addu r13 = 0x0e
    add_mem(enc_i(6'h2b, 1, 13, 16'h0004), 32'h48, WRITE_ACC, 32'h14, 32'h0000000e, -1);
    lw_a = nrows;
    add_mem(enc_i(6'h23, 1, 15, 16'h0008), 32'h4c, READ_ACC, 32'h18, 32'h0, -1);
    add_mem(enc_i(6'h2b, 1, 15, 16'h000c), 32'h50, WRITE_ACC, 32'h1c, 32'h0, lw_a);
    add_op(enc_i(6'h04, 1, 5, 16'h0005), 32'h54);   // beq not taken
    add_op(enc_i(6'h05, 1, 5, 16'h0002), 32'h58);   // bne taken to 0x64
    add_op(enc_i(6'h04, 6, 7, 16'h0001), 32'h64);   // beq taken to 0x6c
    add_op(enc_i(6'h05, 6, 7, 16'h0007), 32'h6c);   // bne not taken
    add_op(enc_j(6'h03, 32'h80), 32'h70);           // jal, r31 = 0x74
    add_mem(enc_i(6'h2b, 1, 31, 16'h0010), 32'h80, WRITE_ACC, 32'h20, 32'h00000074, -1);
    add_op(enc_i(6'h09, 0, 16, 16'h0090), 32'h84);  // addiu r16 = 0x90
    add_op(enc_j(6'h02, 32'hc0), 32'h88);           // j 0xc0
    add_op(enc_r(16, 0, 0, 6'h08), 32'hc0);         // jr back to 0x90
    lw_b = nrows;
    add_mem(enc_i(6'h23, 1, 17, 16'h0014), 32'h90, READ_ACC, 32'h24, 32'h0, -1);
    lw_c = nrows;
    add_mem(enc_i(6'h23, 1, 18, 16'h0018), 32'h94, READ_ACC, 32'h28, 32'h0, -1);
    add_mem(enc_i(6'h2b, 1, 17, 16'h001c), 32'h98, WRITE_ACC, 32'h2c, 32'h0, lw_b);
    add_mem(enc_i(6'h2b, 1, 18, 16'h0020), 32'h9c, WRITE_ACC, 32'h30, 32'h0, lw_c);
    add_op(32'hffff_ffff, 32'ha0);                  // halt
  endtask

  // strobe kind, address and store data of a pending access
  task automatic check_access(input int i);
    logic [31:0] exp_store;
    exp_store = (row_ref[i] >= 0) ? draws[row_ref[i]] : row_dstore[i];
    compare_word("dmemREN", dmemREN, row_kind[i] == READ_ACC);
    compare_word("dmemWEN", dmemWEN, row_kind[i] == WRITE_ACC);
    compare_word("dmemaddr", dmemaddr, row_daddr[i]);
    if (row_kind[i] == WRITE_ACC)
      compare_word("dmemstore", dmemstore, exp_store);
  endtask

  task automatic run_row(input int i);
    @(posedge CLK);
    imemload <= row_instr[i];
    ihit     <= 1'b1;
    dhit     <= 1'b0;
    @(negedge CLK);
    // strobe must be gone the cycle after dhit
    if (prev_mem) begin
      compare_word("dmemREN", dmemREN, 1'b0);
      compare_word("dmemWEN", dmemWEN, 1'b0);
    end
    compare_word("imemaddr", imemaddr, row_pc[i]);
    compare_word("halt", halt, 1'b0);
    prev_mem = (row_kind[i] != NONE_ACC);
    if (row_kind[i] == NONE_ACC) begin
      compare_word("dmemREN", dmemREN, 1'b0);
      compare_word("dmemWEN", dmemWEN, 1'b0);
    end else begin
      // a dead cycle follows a completed access
      while (!(dmemREN || dmemWEN))
        @(negedge CLK);
      check_access(i);
      @(posedge CLK);
      ihit <= 1'b0;
      dhit <= 1'b1;
      if (row_kind[i] == READ_ACC) begin
        dmem[row_daddr[i][7:2]] = $random(seed);
        draws[i] = dmem[row_daddr[i][7:2]];
        dmemload <= draws[i];
      end else begin
        dmem[row_daddr[i][7:2]] = dmemstore;
      end
      @(negedge CLK);
      // held through the dhit cycle
      check_access(i);
    end
  endtask

  initial begin
    seed     = 22939;
    reset    = 1'b1;
    ihit     = 1'b0;
    dhit     = 1'b0;
    imemload = '0;
    dmemload = '0;
    build_program();
    limit = 3 * nrows + 5 + 20;
    repeat (5) @(posedge CLK);
    reset <= 1'b0;
    @(negedge CLK);
    compare_word("imemaddr", imemaddr, cpu_types_pkg::PC_INIT);
    compare_word("imemREN", imemREN, 1'b1);
    compare_word("halt", halt, 1'b0);
    compare_word("dmemREN", dmemREN, 1'b0);
    compare_word("dmemWEN", dmemWEN, 1'b0);
    for (int i = 0; i < nrows; i++)
      run_row(i);
    // halt latches here while fetch keeps hitting on a plain addu
    @(posedge CLK);
    imemload <= enc_r(0, 0, 0, 6'h21);
    @(negedge CLK);
    while (!halt)
      @(negedge CLK);
    repeat (10) begin
      compare_word("imemREN", imemREN, 1'b0);
      compare_word("imemaddr", imemaddr, row_pc[nrows - 1]);
      compare_word("halt", halt, 1'b1);
      @(negedge CLK);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: mips_core.f
design/cpu_types_pkg.sv
design/alu.sv
design/control_unit.sv
design/register_file.sv
design/pc.sv
design/request_unit.sv
design/datapath.sv
tb/datapath_tb.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - design/cpu_types_pkg.sv
  - design/alu.sv
  - design/control_unit.sv
  - design/register_file.sv
  - design/pc.sv
  - design/request_unit.sv
  - design/datapath.sv
  - target: test
    files:
      - tb/datapath_tb.sv
